// File: simd_mul.f
common/simd_mul_pkg.sv
common/pp_stage_if.sv
simd_mul/partial_product_stage.sv
simd_mul/result_pack_stage.sv
design/simd_mul.sv
bench/simd_mul_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the simd_mul testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module simd_mul_tb \
  -Mdir obj_dir \
  -f simd_mul.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vsimd_mul_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

// File: bench/simd_mul_tb.sv
/*
  simd_mul testbench
  directed corners and seeded random traffic, lane model and in-order scoreboard
*/

`timescale 1ns/10ps

module simd_mul_tb;

  localparam int TIMEOUT  = 200;   // cycles allowed per wait
  localparam int N_RANDOM = 3000;  // random traffic cycles

  logic                clk = 1'b0;
  logic                arst_n_i;
  logic                in_valid_i;
  logic                in_ready_o;
  simd_mul_pkg::prec_e mode_i;
  simd_mul_pkg::word_t operand_a_i;
  simd_mul_pkg::word_t operand_b_i;
  logic                res_valid_o;
  logic                res_ready_i;
  simd_mul_pkg::word_t result_o;

  integer              seed = 31588;
  int                  cyc = 0;         // rising edges so far
  int                  val_errs = 0;    // value mismatches
  int                  other_errs = 0;  // timeouts, orphan results
  int                  n_in = 0;
  int                  n_out = 0;
  int                  last_lat = 0;    // edges from accept to result transfer
  logic                hold = 1'b0;     // pending input not taken at next edge
  logic                stalled = 1'b0;  // result was held last cycle
  simd_mul_pkg::word_t held_res;
  simd_mul_pkg::word_t exp_w;
  simd_mul_pkg::word_t exp_q[$];        // expected results, oldest first
  int                  edge_q[$];       // acceptance edge per queued item

  always #4 clk = ~clk;  // 8 ns period

  always @(posedge clk) cyc++;

  simd_mul uut (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .mode_i      (mode_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .result_o    (result_o)
  );

  ////////////////////
  // model and checks
  ////////////////////

  // each lane is the low lane-width bits of the full lane product
  function automatic simd_mul_pkg::word_t lane_model(simd_mul_pkg::prec_e mode,
                                                     simd_mul_pkg::word_t a,
                                                     simd_mul_pkg::word_t b);
    int                  w;
    logic [63:0]         mask;
    logic [63:0]         la;
    logic [63:0]         lb;
    logic [63:0]         p;
    simd_mul_pkg::word_t r;
    w    = (mode == simd_mul_pkg::PREC_INT8) ? 8 : (mode == simd_mul_pkg::PREC_INT16) ? 16 : 32;
    mask = (64'd1 << w) - 64'd1;
    r    = '0;
    for (int i = 0; i < simd_mul_pkg::DATA_W / w; i++) begin
      la = (a >> (i*w)) & mask;
      lb = (b >> (i*w)) & mask;
      p  = la * lb;  // exact, lanes are at most 32 bits
      r  = r | ((p & mask) << (i*w));
    end
    return r;
  endfunction

  function automatic simd_mul_pkg::word_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic check_word(input string name, input simd_mul_pkg::word_t exp,
                            input simd_mul_pkg::word_t got);
    if (got !== exp) begin
      val_errs++;
      $display("Fail at time %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_int(input string name, input int exp, input int got);
    if (got !== exp) begin
      val_errs++;
      $display("Fail at time %0t: %s expected %0d got %0d", $time, name, exp, got);
    end
  endtask

  ////////////////////
  // monitor
  ////////////////////

  // falling edge, every handshake signal is settled here
  always @(negedge clk) begin
    if (arst_n_i) begin
      if (stalled) begin
        check_int("res_valid_o", 1, int'(res_valid_o));  // no drop while stalled
        check_word("result_o", held_res, result_o);
      end
      stalled  = res_valid_o && !res_ready_i;
      held_res = result_o;
      hold     = in_valid_i && !in_ready_o;
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(lane_model(mode_i, operand_a_i, operand_b_i));
        edge_q.push_back(cyc + 1);  // taken at the coming edge
        n_in++;
      end
      if (res_valid_o && res_ready_i) begin
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("result at time %0t arrived with no input waiting for it", $time);
        end else begin
          exp_w    = exp_q.pop_front();
          last_lat = cyc + 1 - edge_q.pop_front();
          check_word("result_o", exp_w, result_o);
        end
        n_out++;
      end
    end
  end

  ////////////////////
  // drive tasks
  ////////////////////

  // present one item, return at the falling edge before its acceptance
  task automatic send(input simd_mul_pkg::prec_e mode, input simd_mul_pkg::word_t a,
                      input simd_mul_pkg::word_t b, output int acc_edge);
    int n;
    n = 0;
    @(posedge clk);
    in_valid_i  <= 1'b1;
    mode_i      <= mode;
    operand_a_i <= a;
    operand_b_i <= b;
    @(negedge clk);
    while (!in_ready_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (n >= TIMEOUT) begin
      other_errs++;
      $display("input was not accepted within %0d cycles", TIMEOUT);
    end
    acc_edge = cyc + 1;
  endtask

  task automatic stop_input();
    @(posedge clk);
    in_valid_i <= 1'b0;
  endtask

  // wait for the pending input to be taken
  task automatic wait_taken();
    int n;
    n = 0;
    @(negedge clk);
    while (in_valid_i && !in_ready_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (n >= TIMEOUT) begin
      other_errs++;
      $display("pending input stayed unaccepted for %0d cycles", TIMEOUT);
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    @(negedge clk);
    while ((exp_q.size() != 0 || res_valid_o) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (n >= TIMEOUT) begin
      other_errs++;
      $display("pipeline did not drain within %0d cycles", TIMEOUT);
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int first_edge;
    int last_edge;
    arst_n_i    <= 1'b0;
    in_valid_i  <= 1'b0;
    mode_i      <= simd_mul_pkg::PREC_INT8;
    operand_a_i <= '0;
    operand_b_i <= '0;
    res_ready_i <= 1'b0;
    repeat (5) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);
    check_int("res_valid_o", 0, int'(res_valid_o));  // empty after reset
    check_int("in_ready_o", 1, int'(in_ready_o));

    // single item latency with open sink
    @(posedge clk) res_ready_i <= 1'b1;
    send(simd_mul_pkg::PREC_INT16, rand_word(), rand_word(), first_edge);
    stop_input();
    drain();
    check_int("latency", 2, last_lat);

    // corners then alternating modes, back to back
    send(simd_mul_pkg::PREC_INT8, '1, '1, first_edge);
    send(simd_mul_pkg::PREC_INT8, '0, rand_word(), last_edge);
    send(simd_mul_pkg::PREC_INT16, '1, '1, last_edge);
    send(simd_mul_pkg::PREC_INT32, '1, '1, last_edge);  // cross sum carry
    for (int i = 0; i < 12; i++) begin
      send(simd_mul_pkg::prec_e'(2'(i % 3)), rand_word(), rand_word(), last_edge);
    end
    stop_input();
    drain();
    check_int("burst_edges", 15, last_edge - first_edge);  // one per cycle

    // random traffic with random back pressure
    repeat (N_RANDOM) begin
      @(posedge clk);
      res_ready_i <= ({$random(seed)} % 10) < 7;  // about 70% ready
      if (!hold) begin
        in_valid_i  <= 1'($random(seed));
        mode_i      <= simd_mul_pkg::prec_e'(2'({$random(seed)} % 3));
        operand_a_i <= (({$random(seed)} % 8) == 0) ? '1 : rand_word();
        operand_b_i <= rand_word();
      end
    end
    @(posedge clk) res_ready_i <= 1'b1;
    wait_taken();
    stop_input();
    drain();
    check_int("result_count", n_in, n_out);

    $display("errors: %0d value mismatches, %0d other failures, %0d inputs, %0d results",
             val_errs, other_errs, n_in, n_out);
    if (val_errs == 0 && other_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: design/simd_mul.sv
/*
  simd_mul
  packed 64 bit integer multiplier, int8/int16/int32 lanes,
  two stage valid/ready pipeline
*/

`timescale 1ns/10ps

module simd_mul (
  input  logic                clk,
  input  logic                arst_n_i,
  // operand side
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  simd_mul_pkg::prec_e mode_i,
  input  simd_mul_pkg::word_t operand_a_i,
  input  simd_mul_pkg::word_t operand_b_i,
  // result side
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output simd_mul_pkg::word_t result_o
);

  pp_stage_if pp_link ();  // stage 1 to stage 2

  // operands in, mode gated partial products out
  partial_product_stage u_pp (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .mode_i      (mode_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .pp_o        (pp_link.src)
  );

  // partial products in, packed lanes out
  result_pack_stage u_pack (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .pp_i        (pp_link.dst),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .result_o    (result_o)
  );

endmodule

// File: simd_mul/result_pack_stage.sv
/*
  result pack stage
  combines the partial products by precision and registers the packed word
*/

`timescale 1ns/10ps

module result_pack_stage (
  input  logic                clk,
  input  logic                arst_n_i,
  pp_stage_if.dst             pp_i,
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output simd_mul_pkg::word_t result_o
);

  localparam int LANE32_W = 2 * simd_mul_pkg::TILE_W;  // int32 lane width

  logic                xfer;        // link handshake
  simd_mul_pkg::word_t packed_res; // next result word
  logic                valid_q;
  simd_mul_pkg::word_t result_q;

  ////////////////////
  // lane packing
  ////////////////////

  always_comb begin
    packed_res = '0;  // illegal mode gives zero
    case (pp_i.mode)
      simd_mul_pkg::PREC_INT8: begin
        for (int b = 0; b < simd_mul_pkg::N_BYTES; b++) begin
          packed_res[b*simd_mul_pkg::BYTE_W +: simd_mul_pkg::BYTE_W] = pp_i.pp.byte_prod[b];
        end
      end
      simd_mul_pkg::PREC_INT16: begin
        for (int t = 0; t < simd_mul_pkg::N_TILES; t++) begin
          // low half of the tile product
          packed_res[t*simd_mul_pkg::TILE_W +: simd_mul_pkg::TILE_W] =
            pp_i.pp.tile_prod[t][simd_mul_pkg::TILE_W-1:0];
        end
      end
      simd_mul_pkg::PREC_INT32: begin
        for (int p = 0; p < simd_mul_pkg::N_PAIRS; p++) begin
          // lo*lo plus cross term one tile up, wraps at 32 bits
          packed_res[p*LANE32_W +: LANE32_W] =
            pp_i.pp.tile_prod[2*p] +
            {pp_i.pp.cross_sum[p], {simd_mul_pkg::TILE_W{1'b0}}};
        end
      end
      default: packed_res = '0;
    endcase
  end

  ////////////////////
  // output register
  ////////////////////

  assign pp_i.ready = !valid_q || res_ready_i;  // empty or draining
  assign xfer       = pp_i.valid && pp_i.ready;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q  <= 1'b0;
      result_q <= '0;
    end else begin
      if (pp_i.ready) valid_q <= pp_i.valid;  // fill or drain
      if (xfer) result_q <= packed_res;
    end
  end

  assign res_valid_o = valid_q;
  assign result_o    = result_q;

  // stalled result must not move under the sink
  a_res_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(result_o)));

endmodule

// File: simd_mul/partial_product_stage.sv
/*
  partial product stage
  splits both operands into lanes, forms the byte, tile and cross products
  and registers only those the selected precision needs
*/

`timescale 1ns/10ps

module partial_product_stage (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  simd_mul_pkg::prec_e mode_i,
  input  simd_mul_pkg::word_t operand_a_i,
  input  simd_mul_pkg::word_t operand_b_i,
  pp_stage_if.src             pp_o
);

  logic [simd_mul_pkg::N_BYTES-1:0][simd_mul_pkg::BYTE_W-1:0]   a_bytes;  // byte lane views
  logic [simd_mul_pkg::N_BYTES-1:0][simd_mul_pkg::BYTE_W-1:0]   b_bytes;
  logic [simd_mul_pkg::N_TILES-1:0][simd_mul_pkg::TILE_W-1:0]   a_tiles;  // tile views
  logic [simd_mul_pkg::N_TILES-1:0][simd_mul_pkg::TILE_W-1:0]   b_tiles;
  logic [simd_mul_pkg::N_BYTES-1:0][simd_mul_pkg::BYTE_W-1:0]   byte_p;   // next byte products
  logic [simd_mul_pkg::N_TILES-1:0][2*simd_mul_pkg::TILE_W-1:0] tile_p;   // next tile products
  logic [simd_mul_pkg::N_PAIRS-1:0][simd_mul_pkg::TILE_W-1:0]   cross_p;  // next cross sums

  logic                       accept;    // input handshake
  logic                       en_byte;   // int8 enable
  logic                       en_cross;  // int32 cross term enable
  logic [simd_mul_pkg::N_TILES-1:0] en_tile;  // per tile enable

  logic                valid_q;
  simd_mul_pkg::prec_e mode_q;
  simd_mul_pkg::pp_t   pp_q;

  assign a_bytes = operand_a_i;  // same bits, lane indexed
  assign b_bytes = operand_b_i;
  assign a_tiles = operand_a_i;
  assign b_tiles = operand_b_i;

  ////////////////////
  // product array
  ////////////////////

  always_comb begin
    for (int b = 0; b < simd_mul_pkg::N_BYTES; b++) begin
      byte_p[b] = simd_mul_pkg::BYTE_W'(a_bytes[b] * b_bytes[b]);  // low byte only
    end
    for (int t = 0; t < simd_mul_pkg::N_TILES; t++) begin
      tile_p[t] = (2*simd_mul_pkg::TILE_W)'(a_tiles[t]) *
                  (2*simd_mul_pkg::TILE_W)'(b_tiles[t]);  // full 32 bit
    end
    for (int p = 0; p < simd_mul_pkg::N_PAIRS; p++) begin
      // both cross terms at 16 bits, carry out falls above lane
      cross_p[p] = simd_mul_pkg::TILE_W'(a_tiles[2*p] * b_tiles[2*p+1] +
                                          a_tiles[2*p+1] * b_tiles[2*p]);
    end
  end

  ////////////////////
  // enable network
  ////////////////////

  assign in_ready_o = !valid_q || pp_o.ready;  // empty or draining
  assign accept     = in_valid_i && in_ready_o;
  assign en_byte    = accept && (mode_i == simd_mul_pkg::PREC_INT8);
  assign en_cross   = accept && (mode_i == simd_mul_pkg::PREC_INT32);

  always_comb begin
    for (int t = 0; t < simd_mul_pkg::N_TILES; t++) begin
      // int32 only uses the low tile of each pair
      en_tile[t] = accept && ((mode_i == simd_mul_pkg::PREC_INT16) ||
                              ((mode_i == simd_mul_pkg::PREC_INT32) && ((t % 2) == 0)));
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      mode_q  <= simd_mul_pkg::PREC_INT8;
      pp_q    <= '0;
    end else begin
      if (in_ready_o) valid_q <= in_valid_i;  // fill or drain
      if (accept) mode_q <= mode_i;
      if (en_byte) pp_q.byte_prod <= byte_p;
      for (int t = 0; t < simd_mul_pkg::N_TILES; t++) begin
        if (en_tile[t]) pp_q.tile_prod[t] <= tile_p[t];  // others keep old value
      end
      if (en_cross) pp_q.cross_sum <= cross_p;
    end
  end

  assign pp_o.valid = valid_q;
  assign pp_o.mode  = mode_q;
  assign pp_o.pp    = pp_q;

  // code 3 never enters the pipe
  a_legal_mode: assert property (@(posedge clk) disable iff (!arst_n_i)
    accept |-> (mode_i inside {simd_mul_pkg::PREC_INT8, simd_mul_pkg::PREC_INT16,
                               simd_mul_pkg::PREC_INT32}));

  // held item survives a stall from the packing stage
  a_pp_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    (pp_o.valid && !pp_o.ready) |=> (pp_o.valid && $stable(pp_o.pp) && $stable(pp_o.mode)));

endmodule

// File: common/pp_stage_if.sv
/*
  pp stage link
  valid/ready channel carrying the mode and the partial products
  from the operand stage to the packing stage
*/

`timescale 1ns/10ps

interface pp_stage_if;

  logic                valid;  // partial products held by source
  logic                ready;  // packing stage can take them
  simd_mul_pkg::prec_e mode;   // precision the products were built for
  simd_mul_pkg::pp_t   pp;     // mode gated partial products

  // operand stage side
  modport src (
    output valid,
    output mode,
    output pp,
    input  ready
  );

  // packing stage side
  modport dst (
    input  valid,
    input  mode,
    input  pp,
    output ready
  );

endinterface

// File: common/simd_mul_pkg.sv
/*
  simd_mul package
  word widths, lane geometry, precision modes and the partial product
  bundle passed between the two multiplier stages
*/

package simd_mul_pkg;

  ////////////////////
  // lane geometry
  ////////////////////

  localparam int DATA_W  = 64;  // operand and result word
  localparam int BYTE_W  = 8;   // int8 lane
  localparam int TILE_W  = 16;  // int16 lane, also the partial product tile
  localparam int N_BYTES = 8;   // int8 lanes per word
  localparam int N_TILES = 4;   // int16 lanes per word
  localparam int N_PAIRS = 2;   // int32 lanes, low tile + high tile each

  ////////////////////
  // types
  ////////////////////

  typedef logic [DATA_W-1:0] word_t;  // one packed operand or result

  // precision select, code 3 is illegal
  typedef enum logic [1:0] {
    PREC_INT8  = 2'd0,  // eight 8 bit lanes
    PREC_INT16 = 2'd1,  // four 16 bit lanes
    PREC_INT32 = 2'd2   // two 32 bit lanes
  } prec_e;

  // partial products loaded by the first stage
  // only the fields needed by the registered mode are meaningful
  typedef struct packed {
    // low 8 bits of each byte lane product
    logic [N_BYTES-1:0][BYTE_W-1:0]   byte_prod;
    // full 32 bit product of each 16x16 tile
    logic [N_TILES-1:0][2*TILE_W-1:0] tile_prod;
    // low 16 bits of lo*hi + hi*lo for each int32 pair
    logic [N_PAIRS-1:0][TILE_W-1:0]   cross_sum;
  } pp_t;

  // int32 lane is built as
  //   tile_prod[lo] + (cross_sum << 16), kept to 32 bits
  // the hi*hi tile only lands above bit 31 and is never needed

endpackage
